// ==== sim.f ====
game_pkg.sv
hex7seg.sv
sequence_memory.sv
round_counters.sv
press_detector.sv
timeout_timer.sv
game_control.sv
game_top.sv
game_assertions.sv
tb_game_checker.sv
tb_game.sv

// ==== Makefile ====
# Verilator build and run of the memory game testbench

TOP = tb_game

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sim.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qF '*** PASSED ***' sim.log || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== tb_game.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free-running clock and a short reset at the start
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

module tb_game;
    import game_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 24;
    localparam int NUM_TESTS      = 5;
    localparam int NAME_W         = 8 * 16;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_WRONG,
        FAULT_SILENT
    } fault_kind_t;

    typedef struct packed {
        logic [NAME_W-1:0]   name;
        logic [NIBBLE_W-1:0] round;
        logic [NIBBLE_W-1:0] pos;
        fault_kind_t         kind;
        game_result_t        result;
    } test_entry_t;

    // ----------------------------------------------------------------------
    // Test table, result bits are {pronto, acertou, errou, timed_out}
    // ----------------------------------------------------------------------
    localparam test_entry_t TESTS [NUM_TESTS] = '{
        '{"full_game",     4'd15, 4'd15, FAULT_NONE,   4'b1100},
        '{"wrong_first",   4'd0,  4'd0,  FAULT_WRONG,  4'b1010},
        '{"wrong_mid",     4'd5,  4'd3,  FAULT_WRONG,  4'b1010},
        '{"silent_round2", 4'd2,  4'd1,  FAULT_SILENT, 4'b1011},
        '{"restart_wrong", 4'd1,  4'd0,  FAULT_WRONG,  4'b1010}
    };

    logic                clock;
    logic                arst_n;
    logic                jogar;
    logic [NIBBLE_W-1:0] botoes;
    game_result_t        result;
    logic [NIBBLE_W-1:0] leds;
    debug_segments_t     debug;
    logic [NAME_W-1:0]   cur_name;
    game_result_t        cur_result;
    logic [NIBBLE_W-1:0] cur_leds;
    debug_segments_t     cur_debug;
    int                  checks_done;
    int                  errors;
    logic [31:0]         lfsr_state;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) clock_gen_i (
        .clock  ( clock  ),
        .arst_n ( arst_n )
    );

    game_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) dut_i (
        .clock  ( clock  ),
        .arst_n ( arst_n ),
        .jogar  ( jogar  ),
        .botoes ( botoes ),
        .result ( result ),
        .leds   ( leds   ),
        .debug  ( debug  )
    );

    tb_game_checker #(.NAME_W(NAME_W)) checker_i (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .result      ( result      ),
        .leds        ( leds        ),
        .debug       ( debug       ),
        .test_name   ( cur_name    ),
        .exp_result  ( cur_result  ),
        .exp_leds    ( cur_leds    ),
        .exp_debug   ( cur_debug   ),
        .checks_done ( checks_done ),
        .errors      ( errors      )
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Lit segments as {g, f, e, d, c, b, a}, the board display is active low
    function automatic logic [6:0] segments_for(input logic [NIBBLE_W-1:0] digit);
        logic [6:0] lit;
        case (digit)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // Displays at the end of a game, memory shows the word at the position
    function automatic debug_segments_t expected_debug(input logic [NIBBLE_W-1:0] round,
                                                       input logic [NIBBLE_W-1:0] pos,
                                                       input game_state_t         shown,
                                                       input logic [NIBBLE_W-1:0] pattern);
        debug_segments_t segs;
        segs.position = segments_for(pos);
        segs.memory   = segments_for(SEQ_TABLE[pos]);
        segs.state    = segments_for(shown);
        segs.press    = segments_for(pattern);
        segs.limit    = segments_for(round);
        return segs;
    endfunction

    // Worst case per test, 6 cycles per press plus game overhead
    function automatic int budget_cycles();
        int cycles;
        int presses;
        cycles = 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            presses = int'(TESTS[t].pos) + 1;
            for (int r = 0; r < int'(TESTS[t].round); r++) begin
                presses += r + 1;
            end
            cycles += 6 * presses + 16;
            if (TESTS[t].kind == FAULT_SILENT) begin
                cycles += TIMEOUT_CYCLES;
            end
        end
        return cycles;
    endfunction

    task automatic pick_wrong_pattern(input  logic [NIBBLE_W-1:0] correct,
                                      output logic [NIBBLE_W-1:0] pattern);
        logic [1:0] index;
        pattern = correct;
        while (pattern == correct) begin
            lfsr_state = lfsr_step(lfsr_state);
            index[0]   = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            index[1]   = lfsr_state[0];
            pattern    = 4'b0001 << index;
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic hold_button(input logic [NIBBLE_W-1:0] pattern);
        botoes = pattern;
        repeat (3) @(negedge clock);
        botoes = '0;
        repeat (3) @(negedge clock);
    endtask

    task automatic run_test(input int index);
        test_entry_t         entry;
        logic [NIBBLE_W-1:0] pattern;
        logic                stop;
        game_state_t         end_state;
        entry      = TESTS[index];
        stop       = 1'b0;
        end_state  = entry.result.acertou ? WON : LOST;
        cur_name   = entry.name;
        cur_result = entry.result;
        cur_leds   = '0;
        jogar      = 1'b1;
        @(negedge clock);
        jogar = 1'b0;
        for (int r = 0; r <= int'(entry.round) && !stop; r++) begin
            for (int p = 0; p <= r && !stop; p++) begin
                if (r == int'(entry.round) && p == int'(entry.pos)
                        && entry.kind != FAULT_NONE) begin
                    stop = 1'b1;
                    if (entry.kind == FAULT_WRONG) begin
                        pick_wrong_pattern(SEQ_TABLE[p], pattern);
                        cur_leds  = pattern;
                        cur_debug = expected_debug(entry.round, entry.pos, end_state, pattern);
                        hold_button(pattern);
                    end else begin
                        cur_debug = expected_debug(entry.round, entry.pos, end_state, cur_leds);
                    end
                end else begin
                    cur_leds  = SEQ_TABLE[p];
                    cur_debug = expected_debug(entry.round, entry.pos, end_state, cur_leds);
                    hold_button(SEQ_TABLE[p]);
                end
            end
        end
        // Game is over once the checker has judged its outcome
        while (checks_done < index + 2) begin
            @(posedge clock);
        end
        @(negedge clock);
    endtask

    initial begin : stimulus
        jogar      = 1'b0;
        botoes     = '0;
        lfsr_state = 32'hc659_4287;
        cur_name   = "reset";
        cur_result = '0;
        cur_leds   = '0;
        cur_debug  = expected_debug('0, '0, IDLE, '0);
        wait (arst_n === 1'b1);
        while (checks_done < 1) begin
            @(posedge clock);
        end
        @(negedge clock);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("Summary: %0d checks run, %0d errors", checks_done, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        int budget;
        budget = budget_cycles();
        #(budget * CLK_PERIOD);
        $display("Watchdog: the game never finished within %0d clock cycles", budget);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_game_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_game_checker #(
    parameter int NAME_W = 128
) (
    input  logic                          clock,
    input  logic                          arst_n,
    input  game_pkg::game_result_t        result,
    input  logic [game_pkg::NIBBLE_W-1:0] leds,
    input  game_pkg::debug_segments_t     debug,
    input  logic [NAME_W-1:0]             test_name,
    input  game_pkg::game_result_t        exp_result,
    input  logic [game_pkg::NIBBLE_W-1:0] exp_leds,
    input  game_pkg::debug_segments_t     exp_debug,
    output int                            checks_done,
    output int                            errors
);
    import game_pkg::*;

    logic pronto_prev;
    logic reset_checked;

    task automatic report_check(input logic [NAME_W-1:0]   name,
                                input game_result_t        want_result,
                                input logic [NIBBLE_W-1:0] want_leds,
                                input debug_segments_t     want_debug);
        checks_done++;
        if (result !== want_result || leds !== want_leds || debug !== want_debug) begin
            errors++;
            $display(
                "** Error: %0s expected res=%b leds=%b seg=%h, actual res=%b leds=%b seg=%h",
                name, want_result, want_leds, want_debug, result, leds, debug);
        end else begin
            $display("Test %0s ok: result=%b leds=%b seg=%h", name, result, leds, debug);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clock) begin
        if (!arst_n) begin
            checks_done   = 0;
            errors        = 0;
            pronto_prev   = 1'b0;
            reset_checked = 1'b0;
        end else begin
            if (!reset_checked) begin
                // Nothing lit before the first game
                report_check("reset", '0, '0, exp_debug);
                reset_checked = 1'b1;
            end else if (result.pronto && !pronto_prev) begin
                report_check(test_name, exp_result, exp_leds, exp_debug);
            end else if (!result.pronto && pronto_prev && result != '0) begin
                errors++;
                $display("Results were not cleared when %0s started", test_name);
            end
            pronto_prev = result.pronto;
        end
    end

endmodule

`default_nettype wire

// ==== game_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_assertions (
    input logic                   clock,
    input logic                   arst_n,
    input logic                   press,
    input game_pkg::game_result_t result
);

    // ----------------------------------------------------------------------
    // Outcome consistency
    // ----------------------------------------------------------------------
    outcome_exclusive: assert property (
        @(posedge clock) disable iff (!arst_n) !(result.acertou && result.errou)
    ) else $error("acertou and errou are high together");

    pronto_has_outcome: assert property (
        @(posedge clock) disable iff (!arst_n) result.pronto |-> (result.acertou || result.errou)
    ) else $error("pronto is high without acertou or errou");

    timeout_is_loss: assert property (
        @(posedge clock) disable iff (!arst_n) result.timed_out |-> result.errou
    ) else $error("timed_out is high without errou");

    // Press strobe lasts one cycle
    press_single_cycle: assert property (
        @(posedge clock) disable iff (!arst_n) press |=> !press
    ) else $error("press is high on two consecutive cycles");

endmodule

bind game_control game_assertions assertions_i (
    .clock  ( clock  ),
    .arst_n ( arst_n ),
    .press  ( press  ),
    .result ( result )
);

`default_nettype wire

// ==== game_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_top #(
    parameter int TIMEOUT_CYCLES = 2000
) (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          jogar,
    input  logic [game_pkg::NIBBLE_W-1:0] botoes,
    output game_pkg::game_result_t        result,
    output logic [game_pkg::NIBBLE_W-1:0] leds,
    output game_pkg::debug_segments_t     debug
);
    import game_pkg::*;

    counter_ctrl_t       ctrl;
    counter_flags_t      flags;
    game_state_t         state;
    logic [NIBBLE_W-1:0] pos;
    logic [NIBBLE_W-1:0] limit;
    logic [NIBBLE_W-1:0] expected;
    logic [NIBBLE_W-1:0] press_value;
    logic                press;
    logic                clear_press;
    logic                wait_active;
    logic                expired;

    // ----------------------------------------------------------------------
    // Control and datapath
    // ----------------------------------------------------------------------
    game_control control_i (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .jogar       ( jogar       ),
        .press       ( press       ),
        .press_value ( press_value ),
        .expected    ( expected    ),
        .flags       ( flags       ),
        .expired     ( expired     ),
        .ctrl        ( ctrl        ),
        .clear_press ( clear_press ),
        .wait_active ( wait_active ),
        .state       ( state       ),
        .result      ( result      )
    );

    round_counters counters_i (
        .clock  ( clock  ),
        .arst_n ( arst_n ),
        .ctrl   ( ctrl   ),
        .pos    ( pos    ),
        .limit  ( limit  ),
        .flags  ( flags  )
    );

    sequence_memory memory_i (
        .pos      ( pos      ),
        .expected ( expected )
    );

    press_detector detector_i (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .botoes      ( botoes      ),
        .clear_press ( clear_press ),
        .press       ( press       ),
        .press_value ( press_value )
    );

    timeout_timer #(
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES )
    ) timer_i (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .wait_active ( wait_active ),
        .expired     ( expired     )
    );

    assign leds = press_value;

    // Debug displays
    hex7seg hex_pos_i   ( .hexa ( pos         ), .display ( debug.position ) );
    hex7seg hex_mem_i   ( .hexa ( expected    ), .display ( debug.memory   ) );
    hex7seg hex_state_i ( .hexa ( state       ), .display ( debug.state    ) );
    hex7seg hex_press_i ( .hexa ( press_value ), .display ( debug.press    ) );
    hex7seg hex_limit_i ( .hexa ( limit       ), .display ( debug.limit    ) );

endmodule

`default_nettype wire

// ==== game_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_control (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          jogar,
    input  logic                          press,
    input  logic [game_pkg::NIBBLE_W-1:0] press_value,
    input  logic [game_pkg::NIBBLE_W-1:0] expected,
    input  game_pkg::counter_flags_t      flags,
    input  logic                          expired,
    output game_pkg::counter_ctrl_t       ctrl,
    output logic                          clear_press,
    output logic                          wait_active,
    output game_pkg::game_state_t         state,
    output game_pkg::game_result_t        result
);
    import game_pkg::*;

    game_state_t state_next;
    logic        match;

    // Only judgement of a press in the whole design
    assign match = (press_value == expected);

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE, WON, LOST: begin
                if (jogar) begin
                    state_next = PREP;
                end
            end
            PREP: state_next = WAIT_PRESS;
            WAIT_PRESS: begin
                // A press in the same cycle as expiry still counts
                if (press) begin
                    state_next = JUDGE;
                end else if (expired) begin
                    state_next = LOST;
                end
            end
            JUDGE: begin
                if (!match) begin
                    state_next = LOST;
                end else if (!flags.pos_at_limit) begin
                    state_next = NEXT_POS;
                end else if (!flags.limit_at_last) begin
                    state_next = NEXT_ROUND;
                end else begin
                    state_next = WON;
                end
            end
            NEXT_POS, NEXT_ROUND: state_next = WAIT_PRESS;
            default: state_next = IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // Datapath commands
    // ----------------------------------------------------------------------
    always_comb begin
        ctrl = '0;
        case (state)
            PREP: begin
                ctrl.clear_pos   = 1'b1;
                ctrl.clear_limit = 1'b1;
            end
            NEXT_POS: ctrl.step_pos = 1'b1;
            NEXT_ROUND: begin
                ctrl.step_limit = 1'b1;
                ctrl.clear_pos  = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    assign clear_press = (state == PREP);
    assign wait_active = (state == WAIT_PRESS);

    // Outcome held from the end of a game until the next start
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (state_next == PREP) begin
            result <= '0;
        end else if (state == JUDGE && state_next == WON) begin
            result.pronto  <= 1'b1;
            result.acertou <= 1'b1;
        end else if (state == JUDGE && state_next == LOST) begin
            result.pronto <= 1'b1;
            result.errou  <= 1'b1;
        end else if (state == WAIT_PRESS && state_next == LOST) begin
            result.pronto    <= 1'b1;
            result.errou     <= 1'b1;
            result.timed_out <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== timeout_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module timeout_timer #(
    parameter int TIMEOUT_CYCLES = 2000
) (
    input  logic clock,
    input  logic arst_n,
    input  logic wait_active,
    output logic expired
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count;

    // Restarts whenever the wait ends, saturates at the limit
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (!wait_active) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count == CNT_W'(TIMEOUT_CYCLES));

endmodule

`default_nettype wire

// ==== press_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

module press_detector (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic [game_pkg::NIBBLE_W-1:0] botoes,
    input  logic                          clear_press,
    output logic                          press,
    output logic [game_pkg::NIBBLE_W-1:0] press_value
);

    logic any_now;
    logic any_prev;
    logic new_press;

    // A press starts when some button goes down after all were up
    assign any_now   = |botoes;
    assign new_press = any_now & ~any_prev;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            any_prev <= 1'b0;
            press    <= 1'b0;
        end else begin
            any_prev <= any_now;
            press    <= new_press;
        end
    end

    // Pattern stays visible on the leds until the next press
    // A press that starts in PREP keeps its pattern for the judge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            press_value <= '0;
        end else if (new_press) begin
            press_value <= botoes;
        end else if (clear_press) begin
            press_value <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== round_counters.sv ====
`timescale 1ns/100ps
`default_nettype none

module round_counters (
    input  logic                          clock,
    input  logic                          arst_n,
    input  game_pkg::counter_ctrl_t       ctrl,
    output logic [game_pkg::NIBBLE_W-1:0] pos,
    output logic [game_pkg::NIBBLE_W-1:0] limit,
    output game_pkg::counter_flags_t      flags
);
    import game_pkg::*;

    // ----------------------------------------------------------------------
    // Position inside the current round
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pos <= '0;
        end else if (ctrl.clear_pos) begin
            pos <= '0;
        end else if (ctrl.step_pos) begin
            pos <= pos + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Last position of the current round
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            limit <= '0;
        end else if (ctrl.clear_limit) begin
            limit <= '0;
        end else if (ctrl.step_limit) begin
            limit <= limit + 1'b1;
        end
    end

    // Round is complete once the position reaches the limit
    always_comb begin
        flags.pos_at_limit  = (pos == limit);
        flags.limit_at_last = (limit == NIBBLE_W'(SEQ_DEPTH - 1));
    end

endmodule

`default_nettype wire

// ==== sequence_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

// Read-only store of the game sequence
module sequence_memory (
    input  logic [game_pkg::NIBBLE_W-1:0] pos,
    output logic [game_pkg::NIBBLE_W-1:0] expected
);
    import game_pkg::*;

    logic [NIBBLE_W-1:0] rom [SEQ_DEPTH];

    // Unpack the table into addressable words
    always_comb begin
        for (int i = 0; i < SEQ_DEPTH; i++) begin
            rom[i] = SEQ_TABLE[i];
        end
    end

    // Asynchronous read, expected follows pos in the same cycle
    assign expected = rom[pos];

endmodule

`default_nettype wire

// ==== hex7seg.sv ====
`timescale 1ns/100ps
`default_nettype none

// Segment order is {g, f, e, d, c, b, a}, a lit segment is 0
module hex7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    always_comb begin
        case (hexa)
            4'h0: display = 7'b1000000;
            4'h1: display = 7'b1111001;
            4'h2: display = 7'b0100100;
            4'h3: display = 7'b0110000;
            4'h4: display = 7'b0011001;
            4'h5: display = 7'b0010010;
            4'h6: display = 7'b0000010;
            4'h7: display = 7'b1111000;
            4'h8: display = 7'b0000000;
            4'h9: display = 7'b0010000;
            4'hA: display = 7'b0001000;
            4'hB: display = 7'b0000011;
            4'hC: display = 7'b1000110;
            4'hD: display = 7'b0100001;
            4'hE: display = 7'b0000110;
            default: display = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    // ----------------------------------------------------------------------
    // Widths and sequence
    // ----------------------------------------------------------------------
    localparam int NIBBLE_W  = 4;
    localparam int SEQ_DEPTH = 16;

    // Entry 0 is the rightmost word, entry 15 the leftmost
    localparam logic [SEQ_DEPTH-1:0][NIBBLE_W-1:0] SEQ_TABLE = {
        4'b0100, 4'b0001, 4'b1000, 4'b1000,
        4'b0100, 4'b0100, 4'b0010, 4'b0010,
        4'b0001, 4'b0001, 4'b0010, 4'b0100,
        4'b1000, 4'b0100, 4'b0010, 4'b0001
    };

    // State codes double as the digit on the state display
    typedef enum logic [NIBBLE_W-1:0] {
        IDLE       = 4'h0,
        PREP       = 4'h1,
        WAIT_PRESS = 4'h2,
        JUDGE      = 4'h3,
        NEXT_POS   = 4'h4,
        NEXT_ROUND = 4'h5,
        WON        = 4'hA,
        LOST       = 4'hE
    } game_state_t;

    // ----------------------------------------------------------------------
    // Control, status and debug bundles
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic clear_pos;
        logic step_pos;
        logic clear_limit;
        logic step_limit;
    } counter_ctrl_t;

    typedef struct packed {
        logic pos_at_limit;
        logic limit_at_last;
    } counter_flags_t;

    typedef struct packed {
        logic pronto;
        logic acertou;
        logic errou;
        logic timed_out;
    } game_result_t;

    typedef struct packed {
        logic [6:0] position;
        logic [6:0] memory;
        logic [6:0] state;
        logic [6:0] press;
        logic [6:0] limit;
    } debug_segments_t;

endpackage

`default_nettype wire
